//--- Bender.yml
package:
  name: fix_parser

sources:
  - src/fix_pkg.sv
  - src/fix_wb_byte_port.sv
  - src/fix_stream_fifo.sv
  - src/fix_tokenizer.sv
  - src/fix_field_extractor.sv
  - src/fix_checksum_check.sv
  - src/fix_parser_top.sv
  - target: test
    files:
      - tests/fix_parser_assertions.sv
      - tests/fix_parser_tb.sv

//--- all.f
src/fix_pkg.sv
src/fix_wb_byte_port.sv
src/fix_stream_fifo.sv
src/fix_tokenizer.sv
src/fix_field_extractor.sv
src/fix_checksum_check.sv
src/fix_parser_top.sv
tests/fix_parser_assertions.sv
tests/fix_parser_tb.sv

//--- src/fix_checksum_check.sv
/*
 * FIX checksum stage: sums field bytes over a message and checks
 * the three-digit tag 10 value against that sum.
 */
`timescale 1ns/1ps
`default_nettype none

module fix_checksum_check import fix_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire fix_field_t field_i,
	input  wire logic       field_valid_i,
	output logic            field_ready_o,
	output fix_field_t      field_o,
	output logic            field_valid_o,
	input  wire logic       field_ready_i,
	output logic            field_done_o,
	output logic            checksum_fail_o
);

	logic [7:0] msg_sum;	// Sum of all bytes before tag 10
	logic [7:0] d_hund;
	logic [7:0] d_tens;
	logic [7:0] d_ones;
	logic [9:0] trailer_val;
	logic       digits_ok;
	logic       sum_match;
	logic       accept;

	assign d_hund = field_i.value[7:0] - ZERO_CHAR;
	assign d_tens = field_i.value[15:8] - ZERO_CHAR;
	assign d_ones = field_i.value[23:16] - ZERO_CHAR;

	// Exactly three decimal digits
	assign digits_ok = (field_i.value_len == VALUE_LEN_W'(3)) &&
		(d_hund < 8'd10) && (d_tens < 8'd10) && (d_ones < 8'd10);
	assign trailer_val = 10'(d_hund) * 10'd100 + 10'(d_tens) * 10'd10 + 10'(d_ones);
	assign sum_match   = digits_ok && (trailer_val == {2'b00, msg_sum});

	assign field_ready_o   = ~field_valid_o | field_ready_i;
	assign accept          = field_valid_i & field_ready_o;
	assign field_done_o    = field_valid_o & field_ready_i;
	assign checksum_fail_o = field_done_o & field_o.end_of_body & ~field_o.checksum_ok;

	always_ff @(posedge clk) begin
		if (rst) begin
			msg_sum       <= '0;
			field_valid_o <= 1'b0;
		end else if (accept) begin
			field_valid_o <= 1'b1;
			if (field_i.start_of_header)
				msg_sum <= field_i.field_sum;	// New message starts here
			else if (field_i.end_of_body)
				msg_sum <= '0;
			else
				msg_sum <= msg_sum + field_i.field_sum;
		end else if (field_ready_i) begin
			field_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			field_o             <= field_i;
			field_o.checksum_ok <= field_i.end_of_body & sum_match;
		end
	end

endmodule

`default_nettype wire

//--- src/fix_field_extractor.sv
/*
 * FIX field extractor: turns a token stream into field records with
 * binary tag, raw value bytes, length, byte sum and header/trailer flags.
 */
`timescale 1ns/1ps
`default_nettype none

module fix_field_extractor import fix_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire fix_token_t tok_i,
	input  wire logic       tok_valid_i,
	output logic            tok_ready_o,
	output fix_field_t      field_o,
	output logic            field_valid_o,
	input  wire logic       field_ready_i
);

	logic [TAG_W-1:0]         tag_acc;	// Decimal tag accumulator
	logic [VALUE_BYTES*8-1:0] value_buf;
	logic [VALUE_LEN_W-1:0]   value_len;
	logic [7:0]               sum_acc;	// Running field byte sum
	logic                     overflow;
	logic                     accept;
	logic [7:0]               digit;
	logic [7:0]               sum_nxt;

	// Refuse tokens only while a finished record is waiting
	assign tok_ready_o = ~field_valid_o;
	assign accept      = tok_valid_i & tok_ready_o;
	assign digit       = tok_i.data - ZERO_CHAR;
	assign sum_nxt     = sum_acc + tok_i.data;

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_acc       <= '0;
			value_buf     <= '0;
			value_len     <= '0;
			sum_acc       <= '0;
			overflow      <= 1'b0;
			field_valid_o <= 1'b0;
		end else begin
			if (field_valid_o & field_ready_i)
				field_valid_o <= 1'b0;
			if (accept) begin
				sum_acc <= sum_nxt;
				case (tok_i.kind)
					TOK_TAG: tag_acc <= TAG_W'(tag_acc * 10) + TAG_W'(digit);
					TOK_VAL: begin
						if (value_len < VALUE_LEN_W'(VALUE_BYTES)) begin
							value_buf[8*value_len +: 8] <= tok_i.data;
							value_len                   <= value_len + 1'b1;
						end else begin
							overflow <= 1'b1;	// Truncate, keep first 32
						end
					end
					TOK_SOH: begin
						field_valid_o <= 1'b1;
						tag_acc       <= '0;	// Ready for next field
						value_buf     <= '0;
						value_len     <= '0;
						sum_acc       <= '0;
						overflow      <= 1'b0;
					end
					default: ;	// TOK_EQ only adds to the sum
				endcase
			end
		end
	end

	// Record payload, loaded as the field closes
	always_ff @(posedge clk) begin
		if (accept && tok_i.kind == TOK_SOH) begin
			field_o.tag             <= tag_acc;
			field_o.value           <= value_buf;
			field_o.value_len       <= value_len;
			field_o.field_sum       <= sum_nxt;	// SOH included
			field_o.start_of_header <= (tag_acc == TAG_BEGIN_STRING);
			field_o.end_of_body     <= (tag_acc == TAG_CHECKSUM);
			field_o.checksum_ok     <= 1'b0;	// Decided downstream
			field_o.overflow        <= overflow;
		end
	end

endmodule

`default_nettype wire

//--- src/fix_parser_top.sv
/*
 * FIX streaming parser top: Wishbone byte port, byte FIFO, tokenizer,
 * field extractor, checksum stage and output field FIFO
 */
`timescale 1ns/1ps
`default_nettype none

module fix_parser_top import fix_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        wb_cyc_i,
	input  wire logic        wb_stb_i,
	input  wire logic        wb_we_i,
	input  wire logic [1:0]  wb_adr_i,
	input  wire logic [7:0]  wb_dat_i,
	output logic      [15:0] wb_dat_o,
	output logic             wb_ack_o,
	output fix_field_t       field_o,
	output logic             field_valid_o,
	input  wire logic        field_ready_i
);

	logic [7:0] port_byte;
	logic       port_byte_valid;
	logic       port_byte_ready;
	logic [7:0] fifo_byte;
	logic       fifo_byte_valid;
	logic       fifo_byte_ready;
	fix_token_t tok;
	logic       tok_valid;
	logic       tok_ready;
	fix_field_t ext_field;
	logic       ext_field_valid;
	logic       ext_field_ready;
	fix_field_t chk_field;
	logic       chk_field_valid;
	logic       chk_field_ready;
	logic       field_done;
	logic       checksum_fail;

	fix_wb_byte_port u_port (
		.clk, .rst, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
		.byte_o(port_byte), .byte_valid_o(port_byte_valid), .byte_ready_i(port_byte_ready),
		.field_done_i(field_done), .checksum_fail_i(checksum_fail)
	);

	fix_stream_fifo #(.payload_t(logic [7:0])) u_byte_fifo (
		.clk, .rst,
		.in_i(port_byte), .in_valid_i(port_byte_valid), .in_ready_o(port_byte_ready),
		.out_o(fifo_byte), .out_valid_o(fifo_byte_valid), .out_ready_i(fifo_byte_ready)
	);

	fix_tokenizer u_tokenizer (
		.clk, .rst,
		.byte_i(fifo_byte), .byte_valid_i(fifo_byte_valid), .byte_ready_o(fifo_byte_ready),
		.tok_o(tok), .tok_valid_o(tok_valid), .tok_ready_i(tok_ready)
	);

	fix_field_extractor u_extractor (
		.clk, .rst,
		.tok_i(tok), .tok_valid_i(tok_valid), .tok_ready_o(tok_ready),
		.field_o(ext_field), .field_valid_o(ext_field_valid), .field_ready_i(ext_field_ready)
	);

	fix_checksum_check u_checksum (
		.clk, .rst,
		.field_i(ext_field), .field_valid_i(ext_field_valid), .field_ready_o(ext_field_ready),
		.field_o(chk_field), .field_valid_o(chk_field_valid), .field_ready_i(chk_field_ready),
		.field_done_o(field_done), .checksum_fail_o(checksum_fail)
	);

	fix_stream_fifo #(.payload_t(fix_field_t)) u_field_fifo (
		.clk, .rst,
		.in_i(chk_field), .in_valid_i(chk_field_valid), .in_ready_o(chk_field_ready),
		.out_o(field_o), .out_valid_o(field_valid_o), .out_ready_i(field_ready_i)
	);

endmodule

`default_nettype wire

//--- src/fix_pkg.sv
/*
 * FIX parser shared definitions: character codes, sizes, Wishbone map,
 * and the token and field records that travel between the pipeline stages.
 */
`default_nettype none

package fix_pkg;

	localparam logic [7:0] SOH_CHAR  = 8'h01;	// Field delimiter
	localparam logic [7:0] EQ_CHAR   = 8'h3d;	// ASCII "="
	localparam logic [7:0] ZERO_CHAR = 8'h30;	// ASCII "0"

	localparam int TAG_W       = 16;	// Binary tag number width
	localparam int VALUE_BYTES = 32;	// Longest value kept
	localparam int VALUE_LEN_W = 6;	// Holds 0 to VALUE_BYTES

	localparam logic [TAG_W-1:0] TAG_BEGIN_STRING = 16'd8;
	localparam logic [TAG_W-1:0] TAG_CHECKSUM     = 16'd10;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;	// Index into FIFO_DEPTH entries
	localparam int FIFO_CNT_W = 3;	// Counts 0 to FIFO_DEPTH

	// Host port address map
	localparam logic [1:0] ADR_BYTE   = 2'd0;
	localparam logic [1:0] ADR_FIELDS = 2'd1;
	localparam logic [1:0] ADR_FAILS  = 2'd2;

	typedef enum logic [1:0] {
		TOK_TAG,	// Tag digit
		TOK_EQ,	// Tag/value separator
		TOK_VAL,	// Value byte
		TOK_SOH	// Field end
	} tok_kind_e;

	typedef struct packed {
		logic [7:0] data;
		tok_kind_e  kind;
	} fix_token_t;

	typedef struct packed {
		logic [TAG_W-1:0]         tag;
		logic [VALUE_BYTES*8-1:0] value;	// First byte in bits 7:0
		logic [VALUE_LEN_W-1:0]   value_len;
		logic [7:0]               field_sum;	// Mod 256, includes "=" and SOH
		logic                     start_of_header;
		logic                     end_of_body;
		logic                     checksum_ok;	// Tag 10 only
		logic                     overflow;
	} fix_field_t;

endpackage

`default_nettype wire

//--- src/fix_stream_fifo.sv
/*
 * Small synchronous valid/ready FIFO for any packed payload type
 */
`timescale 1ns/1ps
`default_nettype none

module fix_stream_fifo import fix_pkg::*; #(
	parameter type payload_t = logic [7:0]
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire payload_t in_i,
	input  wire logic in_valid_i,
	output logic      in_ready_o,
	output payload_t  out_o,
	output logic      out_valid_o,
	input  wire logic out_ready_i
);

	payload_t              mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  push;
	logic                  pop;

	assign in_ready_o  = (count != FIFO_CNT_W'(FIFO_DEPTH));
	assign out_valid_o = (count != '0);
	assign out_o       = mem[rd_ptr];
	assign push        = in_valid_i & in_ready_o;
	assign pop         = out_valid_o & out_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or simultaneous push and pop
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_i;
	end

endmodule

`default_nettype wire

//--- src/fix_tokenizer.sv
/*
 * FIX byte tokenizer: labels each byte as tag digit, separator,
 * value byte or field end, one byte per cycle into a registered slot.
 */
`timescale 1ns/1ps
`default_nettype none

module fix_tokenizer import fix_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic [7:0] byte_i,
	input  wire logic       byte_valid_i,
	output logic            byte_ready_o,
	output fix_token_t      tok_o,
	output logic            tok_valid_o,
	input  wire logic       tok_ready_i
);

	typedef enum logic {
		ST_TAG,
		ST_VALUE
	} tok_state_e;

	tok_state_e state;
	tok_state_e state_nxt;
	tok_kind_e  kind;
	logic       accept;

	// Slot takes a new byte when empty or being drained this cycle
	assign byte_ready_o = ~tok_valid_o | tok_ready_i;
	assign accept       = byte_valid_i & byte_ready_o;

	always_comb begin
		state_nxt = state;
		if (state == ST_TAG) begin
			kind = TOK_TAG;
			if (byte_i == EQ_CHAR) begin
				kind      = TOK_EQ;
				state_nxt = ST_VALUE;
			end
		end else begin
			kind = TOK_VAL;
			if (byte_i == SOH_CHAR) begin
				kind      = TOK_SOH;
				state_nxt = ST_TAG;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_TAG;
			tok_valid_o <= 1'b0;
		end else if (accept) begin
			state       <= state_nxt;
			tok_valid_o <= 1'b1;
		end else if (tok_ready_i) begin
			tok_valid_o <= 1'b0;	// Slot drained, nothing new
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			tok_o.data <= byte_i;
			tok_o.kind <= kind;
		end
	end

endmodule

`default_nettype wire

//--- src/fix_wb_byte_port.sv
/*
 * Wishbone classic host port: byte writes feed the parser stream,
 * reads return the emitted-field and checksum-failure counters.
 */
`timescale 1ns/1ps
`default_nettype none

module fix_wb_byte_port import fix_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        wb_cyc_i,
	input  wire logic        wb_stb_i,
	input  wire logic        wb_we_i,
	input  wire logic [1:0]  wb_adr_i,
	input  wire logic [7:0]  wb_dat_i,
	output logic      [15:0] wb_dat_o,
	output logic             wb_ack_o,
	output logic      [7:0]  byte_o,
	output logic             byte_valid_o,
	input  wire logic        byte_ready_i,
	input  wire logic        field_done_i,
	input  wire logic        checksum_fail_i
);

	logic        req;
	logic        other_req;	// Reads and writes that do not carry a byte
	logic [15:0] fields_cnt;
	logic [15:0] fails_cnt;

	assign req          = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign byte_valid_o = req & wb_we_i & (wb_adr_i == ADR_BYTE);
	assign other_req    = req & ~byte_valid_o;
	assign byte_o       = wb_dat_i;	// Host holds data until ack

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack_o   <= 1'b0;
			fields_cnt <= '0;
			fails_cnt  <= '0;
		end else begin
			// Byte write waits here while the FIFO is full
			wb_ack_o <= (byte_valid_o & byte_ready_i) | other_req;
			if (field_done_i)
				fields_cnt <= fields_cnt + 16'd1;
			if (checksum_fail_i)
				fails_cnt <= fails_cnt + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (other_req & ~wb_we_i) begin
			case (wb_adr_i)
				ADR_FIELDS: wb_dat_o <= fields_cnt;
				ADR_FAILS:  wb_dat_o <= fails_cnt;
				default:    wb_dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tests/fix_parser_assertions.sv
/*
 * Concurrent checks on the FIX parser Wishbone port, output handshake
 * and reset state, bound into the parser top level
 */
`timescale 1ns/1ps
`default_nettype none

module fix_parser_assertions import fix_pkg::*; (
	input wire logic       clk,
	input wire logic       rst,
	input wire logic       wb_cyc_i,
	input wire logic       wb_stb_i,
	input wire logic       wb_ack_o,
	input wire fix_field_t field_o,
	input wire logic       field_valid_o,
	input wire logic       field_ready_i,
	input wire logic       fifo_byte_valid,
	input wire logic       tok_valid,
	input wire logic       ext_field_valid,
	input wire logic       chk_field_valid
);

	int unsigned fail_count = 0;

	// Ack answers a request held on the previous edge
	ack_after_request: assert property (@(posedge clk) disable iff (rst)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else begin
			$error("wb_ack_o raised without a held cyc and stb");
			fail_count++;
		end

	output_stable: assert property (@(posedge clk) disable iff (rst)
		field_valid_o && !field_ready_i |=> field_valid_o && $stable(field_o))
		else begin
			$error("field_o or field_valid_o changed while stalled");
			fail_count++;
		end

	// Second reset edge onward, all registered valids are low
	quiet_in_reset: assert property (@(posedge clk)
		rst ##1 rst |-> !wb_ack_o && !field_valid_o && !fifo_byte_valid &&
			!tok_valid && !ext_field_valid && !chk_field_valid)
		else begin
			$error("valid or ack high during reset");
			fail_count++;
		end

endmodule

bind fix_parser_top fix_parser_assertions u_assertions (
	.clk(clk),
	.rst(rst),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_ack_o(wb_ack_o),
	.field_o(field_o),
	.field_valid_o(field_valid_o),
	.field_ready_i(field_ready_i),
	.fifo_byte_valid(fifo_byte_valid),
	.tok_valid(tok_valid),
	.ext_field_valid(ext_field_valid),
	.chk_field_valid(chk_field_valid)
);

`default_nettype wire

//--- tests/fix_parser_tb.sv
/*
 * Testbench for the FIX parser that replays the trace over Wishbone with
 * random output back-pressure and checks every field record and counter.
 */
`timescale 1ns/1ps
`default_nettype none

module fix_parser_tb import fix_pkg::*; ();

	localparam int          CLK_PERIOD   = 20;
	localparam int          RESET_CYCLES = 10;
	localparam logic [31:0] LFSR_SEED    = 32'h0f013337;
	localparam logic [31:0] LFSR_TAPS    = 32'h80200003;	// x^32 + x^22 + x^2 + x + 1
	localparam string       TRACE_FILE   = "tests/fix_trace.txt";

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [7:0]  wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	fix_field_t  field;
	logic        field_valid;
	logic        field_ready;

	logic [31:0] lfsr;
	logic [7:0]  line_bytes[$];	// Bytes of the W line just parsed
	fix_field_t  expected_q[$];
	string       lines[$];
	int unsigned check_count    = 0;
	int unsigned error_count    = 0;
	int unsigned timeout_cycles = 0;

	fix_parser_top dut0 (
		.clk(clk),
		.rst(rst),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.field_o(field),
		.field_valid_o(field_valid),
		.field_ready_i(field_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		lfsr_next = state >> 1;
		if (state[0])
			lfsr_next = lfsr_next ^ LFSR_TAPS;
	endfunction

	task automatic compare(input string name, input logic [VALUE_BYTES*8-1:0] actual,
			input logic [VALUE_BYTES*8-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0d ns %s got 0x%0h expected 0x%0h",
				$time, name, actual, expected);
		end
	endtask

	// Hex pairs after the leading W, separated by blanks
	function automatic void parse_hex(input string line);
		logic [7:0] value;
		logic [7:0] c;
		int         digits;
		line_bytes.delete();
		value  = '0;
		digits = 0;
		for (int i = 1; i <= line.len(); i++) begin
			c = (i < line.len()) ? line[i] : 8'h20;	// Blank after the last pair
			if (c >= "0" && c <= "9") begin
				value = {value[3:0], 4'(c - "0")};
				digits++;
			end else if (c >= "a" && c <= "f") begin
				value = {value[3:0], 4'(c - "a" + 10)};
				digits++;
			end else if (digits > 0) begin
				line_bytes.push_back(value);
				digits = 0;
			end
		end
	endfunction

	// Field sum covers tag digits, "=", every value byte and SOH
	function automatic fix_field_t expected_field(input int tag, input string val,
			input logic sop, input logic eob, input logic ok, input logic ovf);
		fix_field_t rec;
		string      tag_text;
		rec           = '0;
		tag_text      = $sformatf("%0d", tag);
		rec.field_sum = EQ_CHAR + SOH_CHAR;
		for (int i = 0; i < tag_text.len(); i++)
			rec.field_sum += tag_text[i];
		for (int i = 0; i < val.len(); i++) begin
			rec.field_sum += val[i];
			if (i < VALUE_BYTES)
				rec.value[8*i +: 8] = val[i];	// First byte lowest
		end
		rec.tag             = TAG_W'(tag);
		rec.value_len       = VALUE_LEN_W'((val.len() < VALUE_BYTES) ? val.len() : VALUE_BYTES);
		rec.start_of_header = sop;
		rec.end_of_body     = eob;
		rec.checksum_ok     = ok;
		rec.overflow        = ovf;
		return rec;
	endfunction

	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
			output logic [15:0] rdata);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		do
			@(negedge clk);
		while (!wb_ack);	// Held until the port acks
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	// A record is checked on the falling edge before the rising edge that takes it
	always @(negedge clk) begin : output_monitor
		fix_field_t want;
		if (rst) begin
			field_ready = 1'b0;
		end else begin
			field_ready = lfsr[0];
			lfsr        = lfsr_next(lfsr);
			if (field_valid && field_ready) begin
				if (expected_q.size() == 0) begin
					error_count++;
					$display("unexpected field record with tag %0d at %0d ns", field.tag, $time);
				end else begin
					want = expected_q.pop_front();
					compare("field_o.tag", field.tag, want.tag);
					compare("field_o.value", field.value, want.value);
					compare("field_o.value_len", field.value_len, want.value_len);
					compare("field_o.field_sum", field.field_sum, want.field_sum);
					compare("field_o.start_of_header", field.start_of_header, want.start_of_header);
					compare("field_o.end_of_body", field.end_of_body, want.end_of_body);
					compare("field_o.checksum_ok", field.checksum_ok, want.checksum_ok);
					compare("field_o.overflow", field.overflow, want.overflow);
				end
			end
		end
	end

	initial begin : watchdog
		wait (timeout_cycles != 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("run did not finish within %0d cycles, %0d field records still expected",
			timeout_cycles, expected_q.size());
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int          fd;
		int          byte_total;
		int          tag;
		int          sop;
		int          eob;
		int          ok;
		int          ovf;
		int          fields_exp;
		int          fails_exp;
		int unsigned assert_fails;
		string       line;
		string       val;
		logic [15:0] rdata;

		rst         = 1'b1;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		field_ready = 1'b0;
		lfsr        = LFSR_SEED;
		byte_total  = 0;

		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			error_count++;
			$display("cannot open the trace file %s", TRACE_FILE);
		end else begin
			while ($fgets(line, fd) > 0)
				lines.push_back(line);
			$fclose(fd);
		end

		foreach (lines[i]) begin
			if (lines[i].len() > 0 && lines[i][0] == "W") begin
				parse_hex(lines[i]);
				byte_total += line_bytes.size();
			end
		end
		timeout_cycles = byte_total * 40 + 2000;	// Margin for reset and status reads

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		foreach (lines[i]) begin
			line = lines[i];
			case (line.len() > 0 ? line[0] : 8'h00)
				"W": begin
					parse_hex(line);
					foreach (line_bytes[j])
						wb_access(1'b1, ADR_BYTE, line_bytes[j], rdata);
				end
				"E": begin
					if ($sscanf(line, "E %d %s %d %d %d %d", tag, val, sop, eob, ok, ovf) == 6) begin
						expected_q.push_back(expected_field(tag, val, sop[0], eob[0], ok[0], ovf[0]));
					end else begin
						error_count++;
						$display("trace line %0d is not understood", i + 1);
					end
				end
				"S": begin
					if ($sscanf(line, "S %d %d", fields_exp, fails_exp) == 2) begin
						while (expected_q.size() != 0)
							@(negedge clk);
						repeat (2) @(negedge clk);
						wb_access(1'b0, ADR_FIELDS, 8'h00, rdata);
						compare("wb_dat_o fields", rdata, fields_exp);
						wb_access(1'b0, ADR_FAILS, 8'h00, rdata);
						compare("wb_dat_o fails", rdata, fails_exp);
					end else begin
						error_count++;
						$display("trace line %0d is not understood", i + 1);
					end
				end
				default: ;	// Comments and blank lines
			endcase
		end

		while (expected_q.size() != 0)
			@(negedge clk);
		repeat (20) @(negedge clk);	// Room for a stray extra record

		assert_fails = dut0.u_assertions.fail_count;
		$display("fix_parser_tb checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/fix_trace.txt
# W hex bytes written at address 0. E tag value start_of_header end_of_body checksum_ok overflow
# S fields emitted and checksum failures read back at addresses 1 and 2
# Message 1 with a correct trailer 161
E 8 FIX.4.2 1 0 0 0
E 9 5 0 0 0 0
E 35 0 0 0 0 0
E 10 161 0 1 1 0
W 38 3d 46 49 58 2e 34 2e 32 01
W 39 3d 35 01
W 33 35 3d 30 01
W 31 30 3d 31 36 31 01
# Message 2 with a 40 byte value and a wrong trailer 241, correct would be 242
E 8 FIX.4.2 1 0 0 0
E 58 AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA 0 0 0 1
E 10 241 0 1 0 0
W 38 3d 46 49 58 2e 34 2e 32 01
W 35 38 3d 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41
W 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 01
W 31 30 3d 32 34 31 01
# Message 3 with a correct trailer 079
E 8 FIX.4.4 1 0 0 0
E 49 AB 0 0 0 0
E 10 079 0 1 1 0
W 38 3d 46 49 58 2e 34 2e 34 01
W 34 39 3d 41 42 01
W 31 30 3d 30 37 39 01
S 10 1
